// File: rtl/alu_pkg.sv
package alu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Function codes
	////////////////////////////////////////////////////////////////////////////

	// Six-bit codes, loaded from the low bits of the switch word
	typedef enum logic [5:0] {
		FN_SRL = 6'h02,
		FN_SRA = 6'h03,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_XOR = 6'h26,
		FN_NOR = 6'h27
	} alu_funct_e;

	////////////////////////////////////////////////////////////////////////////
	// Switch word views
	////////////////////////////////////////////////////////////////////////////

	// Function view of the switches
	// Top two switches are don't care here
	typedef struct packed {
		logic [1:0] rsvd;
		alu_funct_e funct;
	} alu_fn_view_t;

	// Same eight switches, read as an operand or as a function load
	typedef union packed {
		logic [7:0]   operand;
		alu_fn_view_t fn;
	} alu_switch_u;

	////////////////////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////////////////////

	// Press strobes, one cycle each
	// Declared MSB first so bit n lines up with button n
	typedef struct packed {
		logic load_op;
		logic load_b;
		logic load_a;
	} btn_press_t;

	// Operation request into the ALU
	typedef struct packed {
		logic       valid;
		logic [7:0] a;
		logic [7:0] b;
		alu_funct_e funct;
	} alu_req_t;

	// Registered ALU result
	// Value and err hold between requests
	typedef struct packed {
		logic       valid;
		logic       err;
		logic [7:0] value;
	} alu_res_t;

endpackage

// File: rtl/button_conditioner.sv
`timescale 1ns/1ns

module button_conditioner import alu_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 1_000_000
) (
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic [2:0] i_bot,
	output btn_press_t o_press
);

	// Counter must reach DEBOUNCE_CYCLES-1
	localparam int               CNT_W    = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic [2:0]       sync_q1;
	logic [2:0]       sync_q2;
	logic [CNT_W-1:0] stable_cnt_q [3];
	logic [2:0]       level_q;
	logic [2:0]       level_d1_q;
	btn_press_t       press_q;

	////////////////////////////////////////////////////////////////////////////
	// Two-flop synchronizer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= i_bot;
			sync_q2 <= sync_q1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Debounce, one counter per button
	////////////////////////////////////////////////////////////////////////////

	// Counts clocks the synced level differs from the accepted one
	// Any sample back at the accepted level restarts the count
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			level_q <= '0;
			for (int i = 0; i < 3; i++) begin
				stable_cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (sync_q2[i] == level_q[i]) begin
					stable_cnt_q[i] <= '0;
				end else if (stable_cnt_q[i] == CNT_LAST) begin
					// Held long enough, take the new level
					level_q[i]      <= sync_q2[i];
					stable_cnt_q[i] <= '0;
				end else begin
					stable_cnt_q[i] <= stable_cnt_q[i] + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Rising edge of accepted level
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			level_d1_q <= '0;
			press_q    <= '0;
		end else begin
			level_d1_q <= level_q;
			// Release gives no strobe
			press_q    <= btn_press_t'(level_q & ~level_d1_q);
		end
	end

	assign o_press = press_q;

	// Strobe never stretches past one clock
	for (genvar g = 0; g < 3; g++) begin : g_press_chk
		assert property (@(posedge clk) disable iff (!i_arst_n)
			press_q[g] |=> !press_q[g])
			else $error("%0t press[%0d] held longer than one cycle", $time, g);
	end

endmodule

// File: rtl/operand_latch.sv
`timescale 1ns/1ns

module operand_latch import alu_pkg::*; (
	input  logic        clk,
	input  logic        i_arst_n,
	input  alu_switch_u i_op,
	input  btn_press_t  i_press,
	output alu_req_t    o_req
);

	logic [7:0] a_q;
	logic [7:0] b_q;
	alu_funct_e funct_q;
	logic       valid_q;

	////////////////////////////////////////////////////////////////////////////
	// Operand and function registers
	////////////////////////////////////////////////////////////////////////////

	// Operand view of the switches
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			a_q <= '0;
			b_q <= '0;
		end else begin
			if (i_press.load_a) begin
				a_q <= i_op.operand;
			end
			if (i_press.load_b) begin
				b_q <= i_op.operand;
			end
		end
	end

	// Function view, top two switches dropped
	// Button 2 latches the code and fires the request together
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			funct_q <= FN_ADD;
			valid_q <= 1'b0;
		end else begin
			if (i_press.load_op) begin
				funct_q <= i_op.fn.funct;
			end
			valid_q <= i_press.load_op;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Request out
	////////////////////////////////////////////////////////////////////////////

	// Same-cycle loads of A or B land before valid is seen
	assign o_req.valid = valid_q;
	assign o_req.a     = a_q;
	assign o_req.b     = b_q;
	assign o_req.funct = funct_q;

endmodule

// File: rtl/alu_core.sv
`timescale 1ns/1ns

module alu_core import alu_pkg::*; (
	input  logic     clk,
	input  logic     i_arst_n,
	input  alu_req_t i_req,
	output alu_res_t o_res
);

	logic [7:0] value_d;
	logic       err_d;
	logic [2:0] shamt;
	alu_res_t   res_q;

	// Only three bits of B matter for shifts
	assign shamt = i_req.b[2:0];

	////////////////////////////////////////////////////////////////////////////
	// Operation decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		value_d = '0;
		err_d   = 1'b0;
		case (i_req.funct)
			FN_ADD: begin
				// Wraps at 8 bits with no carry kept
				value_d = i_req.a + i_req.b;
			end
			FN_SUB: begin
				value_d = i_req.a - i_req.b;
			end
			FN_AND: begin
				value_d = i_req.a & i_req.b;
			end
			FN_OR: begin
				value_d = i_req.a | i_req.b;
			end
			FN_XOR: begin
				value_d = i_req.a ^ i_req.b;
			end
			FN_NOR: begin
				value_d = ~(i_req.a | i_req.b);
			end
			FN_SRL: begin
				value_d = i_req.a >> shamt;
			end
			FN_SRA: begin
				// Sign bit of A fills from the top
				value_d = 8'($signed(i_req.a) >>> shamt);
			end
			default: begin
				// Unknown code gives zero and sets the flag
				value_d = '0;
				err_d   = 1'b1;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			res_q <= '0;
		end else begin
			res_q.valid <= i_req.valid;
			// Value and err only move on a request
			if (i_req.valid) begin
				res_q.value <= value_d;
				res_q.err   <= err_d;
			end
		end
	end

	assign o_res = res_q;

	// Result valid trails request valid by exactly one clock
	assert property (@(posedge clk) disable iff (!i_arst_n)
		o_res.valid == $past(i_req.valid))
		else $error("%0t o_res.valid %b, expected %b", $time, o_res.valid,
			$past(i_req.valid));

endmodule

// File: rtl/sseg_display.sv
`timescale 1ns/1ns

module sseg_display #(
	parameter int REFRESH_CYCLES = 50_000
) (
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic [7:0] i_value,
	output logic [6:0] o_sseg,
	output logic [1:0] o_an
);

	localparam int               CNT_W    = $clog2(REFRESH_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(REFRESH_CYCLES - 1);

	logic [CNT_W-1:0] refresh_cnt_q;
	logic             digit_sel_q;
	logic [3:0]       nibble;

	////////////////////////////////////////////////////////////////////////////
	// Refresh timer and digit select
	////////////////////////////////////////////////////////////////////////////

	// Digit 0 first out of reset
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			refresh_cnt_q <= '0;
			digit_sel_q   <= 1'b0;
		end else if (refresh_cnt_q == CNT_LAST) begin
			refresh_cnt_q <= '0;
			digit_sel_q   <= ~digit_sel_q;
		end else begin
			refresh_cnt_q <= refresh_cnt_q + 1'b1;
		end
	end

	// Anodes active low
	// 2'b10 lights the low nibble and 2'b01 the high one
	assign o_an   = digit_sel_q ? 2'b01 : 2'b10;
	assign nibble = digit_sel_q ? i_value[7:4] : i_value[3:0];

	////////////////////////////////////////////////////////////////////////////
	// Hex to segments
	////////////////////////////////////////////////////////////////////////////

	// Active high, bit 6 is g down to bit 0 is a
	always_comb begin
		case (nibble)
			4'h0: o_sseg = 7'h3f;
			4'h1: o_sseg = 7'h06;
			4'h2: o_sseg = 7'h5b;
			4'h3: o_sseg = 7'h4f;
			4'h4: o_sseg = 7'h66;
			4'h5: o_sseg = 7'h6d;
			4'h6: o_sseg = 7'h7d;
			4'h7: o_sseg = 7'h07;
			4'h8: o_sseg = 7'h7f;
			4'h9: o_sseg = 7'h6f;
			4'ha: o_sseg = 7'h77;
			// Lower case b and d to tell them from 8 and 0
			4'hb: o_sseg = 7'h7c;
			4'hc: o_sseg = 7'h39;
			4'hd: o_sseg = 7'h5e;
			4'he: o_sseg = 7'h79;
			default: o_sseg = 7'h71;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// One digit lit at a time
	assert property (@(posedge clk)
		$onehot(~o_an))
		else $error("%0t o_an %b, expected one low bit", $time, o_an);

endmodule

// File: rtl/alu_board_top.sv
`timescale 1ns/1ns

module alu_board_top import alu_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 1_000_000,
	parameter int REFRESH_CYCLES  = 50_000
) (
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic [7:0] i_op,
	input  logic [2:0] i_bot,
	output logic [7:0] o_led,
	output logic       o_err,
	output logic [6:0] o_sseg,
	output logic [1:0] o_an
);

	alu_switch_u op_word;
	btn_press_t  press;
	alu_req_t    req;
	alu_res_t    res;

	// Raw switches, decoded downstream in two ways
	assign op_word = i_op;

	////////////////////////////////////////////////////////////////////////////
	// Stage chain
	////////////////////////////////////////////////////////////////////////////

	// Buttons to press strobes
	button_conditioner #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_button_conditioner (
		.clk     (clk),
		.i_arst_n(i_arst_n),
		.i_bot   (i_bot),
		.o_press (press)
	);

	// Strobes to operation request
	operand_latch u_operand_latch (
		.clk     (clk),
		.i_arst_n(i_arst_n),
		.i_op    (op_word),
		.i_press (press),
		.o_req   (req)
	);

	alu_core u_alu_core (
		.clk     (clk),
		.i_arst_n(i_arst_n),
		.i_req   (req),
		.o_res   (res)
	);

	// Result on two hex digits
	sseg_display #(
		.REFRESH_CYCLES(REFRESH_CYCLES)
	) u_sseg_display (
		.clk     (clk),
		.i_arst_n(i_arst_n),
		.i_value (res.value),
		.o_sseg  (o_sseg),
		.o_an    (o_an)
	);

	assign o_led = res.value;
	assign o_err = res.err;

endmodule

// File: sim/alu_board_tb.sv
`timescale 1ns/1ns

module alu_board_tb;

	localparam int DEBOUNCE    = 8;
	localparam int REFRESH     = 4;
	localparam int NUM_OPS     = 68;
	localparam int HOLD        = 12;
	localparam int GAP         = 12;
	localparam int LONG_HOLD   = 60;
	localparam int GLITCH_LEN  = 5;
	localparam int CHECK_DELAY = 40;
	localparam int TIMEOUT     = NUM_OPS * 80 + 200;
	localparam int MODE_NORMAL  = 0;
	localparam int MODE_HOLD_A  = 1;
	localparam int MODE_HOLD_OP = 2;
	localparam int MODE_GLITCH  = 3;

	// Expected response of one operation
	typedef struct packed {
		logic       err;
		logic [7:0] value;
	} model_out_t;

	logic       clk;
	logic       i_arst_n;
	logic [7:0] i_op;
	logic [2:0] i_bot;
	logic [7:0] o_led;
	logic       o_err;
	logic [6:0] o_sseg;
	logic [1:0] o_an;

	int         cycle         = 0;
	int         errors        = 0;
	int         checks        = 0;
	int         ops_seen      = 0;
	int         ops_expected  = 0;
	int         release_cycle = -1000;
	int         an_lo_cnt     = 0;
	int         an_hi_cnt     = 0;
	logic       led_window;
	logic       check_now;
	logic [7:0] model_a;
	logic [7:0] model_b;
	model_out_t expected;

	logic [5:0] codes [8] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h27, 6'h02, 6'h03};

	alu_board_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE),
		.REFRESH_CYCLES (REFRESH)
	) UUT (
		.clk     (clk),
		.i_arst_n(i_arst_n),
		.i_op    (i_op),
		.i_bot   (i_bot),
		.o_led   (o_led),
		.o_err   (o_err),
		.o_sseg  (o_sseg),
		.o_an    (o_an)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic is_defined(input logic [5:0] code);
		return (code == 6'h20) || (code == 6'h22) || (code == 6'h24) || (code == 6'h25) ||
			(code == 6'h26) || (code == 6'h27) || (code == 6'h02) || (code == 6'h03);
	endfunction

	function automatic model_out_t alu_model(input logic [7:0] a, input logic [7:0] b,
		input logic [5:0] code);
		model_out_t r;
		int         sh;
		r  = '0;
		sh = int'(b[2:0]);
		case (code)
			6'h20: r.value = a + b;
			6'h22: r.value = a - b;
			6'h24: r.value = a & b;
			6'h25: r.value = a | b;
			6'h26: r.value = a ^ b;
			6'h27: r.value = ~(a | b);
			6'h02: begin
				r.value = a;
				for (int k = 0; k < sh; k++) begin
					r.value = {1'b0, r.value[7:1]};
				end
			end
			6'h03: begin
				// Copy the sign bit in on every step
				r.value = a;
				for (int k = 0; k < sh; k++) begin
					r.value = {r.value[7], r.value[7:1]};
				end
			end
			default: r.err = 1'b1;
		endcase
		return r;
	endfunction

	// Segments g..a, active high
	function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
		logic [6:0] table_q [16];
		table_q = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
			7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
		return table_q[nib];
	endfunction

	function automatic logic [5:0] pick_undefined_code();
		logic [5:0] c;
		c = 6'($urandom);
		while (is_defined(c)) begin
			c = 6'($urandom);
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Clock, cycle count, timeout
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (UUT.res.valid) begin
			ops_seen <= ops_seen + 1;
		end
		if (check_now) begin
			checks <= checks + 1;
		end
		if (o_an == 2'b10) begin
			an_lo_cnt <= an_lo_cnt + 1;
		end
		if (o_an == 2'b01) begin
			an_hi_cnt <= an_hi_cnt + 1;
		end
		if (cycle >= TIMEOUT) begin
			$display("timeout after %0d cycles, stimulus did not finish", cycle);
			$display("ops %0d checks %0d errors %0d", ops_expected, checks, errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Result settled long before this point
	assign check_now = (cycle == release_cycle + CHECK_DELAY);

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk) check_now |-> o_led == expected.value)
		else begin
			errors++;
			$display("error %0t o_led %h expected %h", $time, o_led, expected.value);
		end

	// Undefined code sets it and the next good code clears it
	assert property (@(posedge clk) check_now |-> o_err == expected.err)
		else begin
			errors++;
			$display("error %0t o_err %b expected %b", $time, o_err, expected.err);
		end

	// One result per function press whether held or not
	assert property (@(posedge clk) check_now |-> ops_seen == ops_expected)
		else begin
			errors++;
			$display("error %0t ops_seen %0d expected %0d", $time, ops_seen, ops_expected);
		end

	// Glitches and held buttons leave the LEDs alone
	assert property (@(posedge clk) disable iff (!i_arst_n)
		!led_window |-> $stable(o_led))
		else begin
			errors++;
			$display("error %0t o_led %h expected %h", $time, o_led, $past(o_led));
		end

	assert property (@(posedge clk) disable iff (!i_arst_n)
		!led_window |-> $stable(o_err))
		else begin
			errors++;
			$display("error %0t o_err %b expected %b", $time, o_err, $past(o_err));
		end

	assert property (@(posedge clk) disable iff (!i_arst_n)
		UUT.res.valid |-> led_window)
		else begin
			errors++;
			$display("error %0t res.valid 1 expected 0, operation without a press", $time);
		end

	assert property (@(posedge clk) disable iff (!i_arst_n)
		o_an == 2'b10 |-> o_sseg == seg_pattern(o_led[3:0]))
		else begin
			errors++;
			$display("error %0t o_sseg %h expected %h", $time, o_sseg,
				seg_pattern(o_led[3:0]));
		end

	assert property (@(posedge clk) disable iff (!i_arst_n)
		o_an == 2'b01 |-> o_sseg == seg_pattern(o_led[7:4]))
		else begin
			errors++;
			$display("error %0t o_sseg %h expected %h", $time, o_sseg,
				seg_pattern(o_led[7:4]));
		end

	// In reset and on the first cycle out of it
	assert property (@(posedge clk)
		(!i_arst_n || $rose(i_arst_n)) |-> (o_led == 8'h00 && o_err == 1'b0 && o_an == 2'b10))
		else begin
			errors++;
			$display("error %0t o_led/o_err/o_an %h/%b/%b expected 00/0/10", $time,
				o_led, o_err, o_an);
		end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Lands 1 ns past a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic press_button(input int idx, input logic [7:0] word, input int hold);
		i_op       = word;
		i_bot[idx] = 1'b1;
		wait_cycles(hold);
		i_bot[idx] = 1'b0;
		wait_cycles(GAP);
	endtask

	// Pulses shorter than the debounce time
	task automatic glitch_buttons(input logic [7:0] word);
		i_op = word;
		for (int idx = 0; idx < 3; idx++) begin
			i_bot[idx] = 1'b1;
			wait_cycles(GLITCH_LEN);
			i_bot[idx] = 1'b0;
			wait_cycles(GAP);
		end
	endtask

	task automatic run_op(input logic [7:0] a_val, input logic [7:0] b_val,
		input logic [7:0] fn_word, input int mode);
		if (mode == MODE_GLITCH) begin
			// A and B keep their old values
			glitch_buttons(~a_val);
		end else begin
			if (mode == MODE_HOLD_A) begin
				// Switches move while button 0 stays down
				i_op     = a_val;
				i_bot[0] = 1'b1;
				wait_cycles(20);
				i_op = ~a_val;
				wait_cycles(LONG_HOLD - 20);
				i_bot[0] = 1'b0;
				wait_cycles(GAP);
			end else begin
				press_button(0, a_val, HOLD);
			end
			model_a = a_val;
			press_button(1, b_val, HOLD);
			model_b = b_val;
		end
		// Function load launches the operation
		ops_expected++;
		led_window = 1'b1;
		i_op       = fn_word;
		i_bot[2]   = 1'b1;
		wait_cycles(mode == MODE_HOLD_OP ? LONG_HOLD : HOLD);
		i_bot[2]      = 1'b0;
		expected      = alu_model(model_a, model_b, fn_word[5:0]);
		release_cycle = cycle;
		wait_cycles(GAP);
		led_window = 1'b0;
	endtask

	initial begin
		logic [7:0] a_val;
		logic [7:0] b_val;
		logic [5:0] code;
		logic [1:0] top2;
		int         mode;
		i_arst_n   = 1'b0;
		i_op       = 8'h00;
		i_bot      = 3'b000;
		led_window = 1'b0;
		model_a    = 8'h00;
		model_b    = 8'h00;
		expected   = '0;
		void'($urandom(32'hb82d_cd99));
		wait_cycles(16);
		i_arst_n = 1'b1;
		wait_cycles(4);

		for (int n = 0; n < NUM_OPS; n++) begin
			a_val = 8'($urandom);
			b_val = 8'($urandom);
			top2  = 2'($urandom);
			if (n < 8) begin
				code = codes[n];
			end else if (n == 12 || n == 29 || n == 44 || n == 60) begin
				code = pick_undefined_code();
			end else begin
				code = codes[3'($urandom)];
			end
			// Force a borrow and a negative shift early on
			if (n < 8 && code == 6'h22) begin
				a_val = 8'h05;
				b_val = 8'h9a;
			end
			if (n < 8 && code == 6'h03) begin
				a_val[7]   = 1'b1;
				b_val[2:0] = 3'd3;
			end
			mode = (n == 20) ? MODE_HOLD_A : (n == 33) ? MODE_HOLD_OP :
				(n == 47) ? MODE_GLITCH : MODE_NORMAL;
			run_op(a_val, b_val, {top2, code}, mode);
		end
		wait_cycles(CHECK_DELAY + 20);

		if (an_lo_cnt == 0 || an_hi_cnt == 0) begin
			errors++;
			$display("display never showed both digits, low %0d high %0d",
				an_lo_cnt, an_hi_cnt);
		end
		if (checks != NUM_OPS) begin
			errors++;
			$display("only %0d of %0d result checks were reached", checks, NUM_OPS);
		end
		$display("ops %0d checks %0d errors %0d", ops_expected, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: alu_board.f
rtl/alu_pkg.sv
rtl/button_conditioner.sv
rtl/operand_latch.sv
rtl/alu_core.sv
rtl/sseg_display.sv
rtl/alu_board_top.sv
sim/alu_board_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU board testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module alu_board_tb \
	-f alu_board.f \
	-Mdir obj_dir

output=$(./obj_dir/Valu_board_tb)
echo "$output"

if grep -q "^TESTBENCH PASSED$" <<< "$output"; then
	exit 0
else
	exit 1
fi
